// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= power_subsys_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a run that stops early has no pass line
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
source/power_pkg.sv
source/irq_wake_sync.sv
source/power_ctrl.sv
source/pwrup_link.sv
source/power_subsys_top.sv
test/power_subsys_chk.sv
test/power_subsys_tb.sv

// File: source/irq_wake_sync.sv
// ----------------------------------------------------------
// interrupt input side of the sleep/wake subsystem
// brings the asynchronous irq lines into clk_always_on,
// masks them with the CSR enable bits and reduces them to
// one level-sensitive wake request for a core on WFI
// ----------------------------------------------------------

`timescale 1ns/1ns

module irq_wake_sync (
	input  logic                clk_always_on,
	input  logic                rst_n,
	input  power_pkg::irq_vec_t irq,
	input  power_pkg::irq_vec_t irq_enable,
	output logic                wfi_wakeup_req
);
	import power_pkg::*;

	// ----------------------------------------------------------
	// synchronizer chains
	// ----------------------------------------------------------

	// stage 0 samples the raw lines, the last stage is the one that is safe to use
	irq_vec_t sync_q [sync_stages];

	// synchronized copy of the interrupt lines
	irq_vec_t irq_sync;

	// lines that are both pending and enabled
	irq_vec_t irq_masked;

	// every line gets its own chain, all clocked by the always-on clock,
	// so interrupts are still seen while the core clock is gated off
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < sync_stages; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= irq;
			for (int i = 1; i < sync_stages; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign irq_sync = sync_q[sync_stages-1];

	// ----------------------------------------------------------
	// mask and reduce
	// ----------------------------------------------------------

	// the enable mask sits behind the registers, so a CSR write that
	// enables an already pending line raises the request in the same cycle
	assign irq_masked = irq_sync & irq_enable;

	// level request, held for as long as any enabled line stays high
	// the core clears the source through its own handler, not through us
	assign wfi_wakeup_req = |irq_masked;

endmodule

// File: source/power_ctrl.sv
// ----------------------------------------------------------
// sleep/wake power state machine for the core
// decides from the CSR permission bits whether a stalled
// core just waits, has its clock gated or has its power
// removed, runs the four-phase power handshake and issues
// a single stall_release pulse when the core may continue
// ----------------------------------------------------------

`timescale 1ns/1ns

module power_ctrl (
	input  logic clk_always_on,
	input  logic rst_n,

	// permission bits from the CSR file
	input  logic allow_clkgate,
	input  logic allow_power_down,
	input  logic allow_sleep_on_block,

	// frontend has gone quiet against the WFI stall
	input  logic frontend_pwrdown_ok,

	// core stall status and wake sources
	input  logic sleeping_on_wfi,
	input  logic sleeping_on_block,
	input  logic wfi_wakeup_req,
	input  logic block_wakeup_req_pulse,

	// synchronized acknowledge from the fabric power controller
	input  logic ack_sync,

	// power request to the fabric, clock enable for the external gate
	output logic pwrup_req,
	output logic clk_en,

	// one cycle pulse that lets the stalled instruction retire
	output logic stall_release
);
	import power_pkg::*;

	sleep_state_t state;

	// level version of the block wakeup pulse
	logic block_wakeup_req;

	// core is stalled on either kind of sleep
	logic sleep_any;

	// a wake source relevant to the current kind of stall is active
	logic active_wake_req;

	// at least one low power mode is allowed for this kind of stall
	logic sleep_permitted;

	assign sleep_any = sleeping_on_wfi || sleeping_on_block;

	// a block stall also wakes on interrupts, a WFI stall only on interrupts
	assign active_wake_req = (sleeping_on_block && (block_wakeup_req || wfi_wakeup_req))
		|| (sleeping_on_wfi && wfi_wakeup_req);

	// blocking only goes to a low power mode when the CSR allows it
	assign sleep_permitted = (allow_power_down || allow_clkgate)
		&& (sleeping_on_wfi || allow_sleep_on_block);

	// ----------------------------------------------------------
	// power state machine
	// ----------------------------------------------------------

	// pwrup_req comes out of reset high, on the assumption that the
	// fabric also holds its acknowledge high through reset
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			state         <= st_awake;
			pwrup_req     <= 1'b1;
			clk_en        <= 1'b1;
			stall_release <= 1'b0;
		end else begin
			// release is a pulse, it only lasts the cycle it is set in
			stall_release <= 1'b0;
			case (state)
				st_awake: begin
					// while the release pulse is out the stall is still visible,
					// the instruction only leaves it at the end of this cycle
					if (sleep_any && !stall_release) begin
						if (active_wake_req) begin
							// wake already pending, so skip the low power states
							stall_release <= 1'b1;
						end else if (sleep_permitted && frontend_pwrdown_ok) begin
							// drop whatever the CSR allows
							pwrup_req <= !allow_power_down;
							clk_en    <= !allow_clkgate;
							if (allow_power_down) begin
								state <= st_enter_asleep;
							end else begin
								state <= st_asleep;
							end
						end
						// otherwise stay stalled at full power, and wait either
						// for the frontend to go quiet or for a wake source
					end
				end
				st_enter_asleep: begin
					// fabric has seen the request fall once the ack goes low
					if (!ack_sync) begin
						state <= st_asleep;
					end
				end
				st_asleep: begin
					if (active_wake_req) begin
						pwrup_req <= 1'b1;
						clk_en    <= 1'b1;
						// a clock-gate-only sleep also passes through here, which
						// gives the gate cell one cycle to restart the core clock
						state     <= st_enter_awake;
					end
				end
				st_enter_awake: begin
					// ack is still high when power was never removed
					if (ack_sync || !allow_power_down) begin
						stall_release <= 1'b1;
						state         <= st_awake;
					end
				end
				default: begin
					state <= st_awake;
				end
			endcase
		end
	end

	// ----------------------------------------------------------
	// sticky block wakeup
	// ----------------------------------------------------------

	// an unblock that comes before the block is remembered, so the next
	// block falls straight through; releasing a block stall consumes it,
	// and a pulse in that same cycle wins over the clear
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			block_wakeup_req <= 1'b0;
		end else if (block_wakeup_req_pulse) begin
			block_wakeup_req <= 1'b1;
		end else if (sleeping_on_block && stall_release) begin
			block_wakeup_req <= 1'b0;
		end
	end

endmodule

// File: source/power_pkg.sv
// ----------------------------------------------------------
// shared widths, synchronizer depth and state encodings for
// the always-on sleep/wake subsystem
// import with power_pkg::* inside a module body, or use
// scoped names such as power_pkg::irq_vec_t in port lists
// ----------------------------------------------------------

package power_pkg;

	// number of external interrupt lines that can wake the core
	localparam int num_irq = 4;

	// flop depth of every clock domain crossing chain in the subsystem
	localparam int sync_stages = 2;

	// one bit per interrupt line, used for both the lines and the enable mask
	typedef logic [num_irq-1:0] irq_vec_t;

	// power state machine in power_ctrl
	typedef enum logic [1:0] {
		st_awake        = 2'h0,
		st_enter_asleep = 2'h1,
		st_asleep       = 2'h2,
		st_enter_awake  = 2'h3
	} sleep_state_t;

	// phase of the four-phase request/acknowledge power link
	typedef enum logic [1:0] {
		link_up       = 2'h0,
		link_dropping = 2'h1,
		link_down     = 2'h2,
		link_raising  = 2'h3
	} link_state_t;

endpackage

// File: source/power_subsys_top.sv
// ----------------------------------------------------------
// top level of the always-on sleep/wake subsystem
// connects the interrupt synchronizer, the power state
// machine and the power-up link to the core, CSR and
// fabric ports, with no logic of its own
// ----------------------------------------------------------

`timescale 1ns/1ns

module power_subsys_top (
	input  logic                   clk_always_on,
	input  logic                   rst_n,
	input  power_pkg::irq_vec_t    irq,
	input  power_pkg::irq_vec_t    irq_enable,
	input  logic                   allow_clkgate,
	input  logic                   allow_power_down,
	input  logic                   allow_sleep_on_block,
	input  logic                   frontend_pwrdown_ok,
	input  logic                   sleeping_on_wfi,
	input  logic                   sleeping_on_block,
	input  logic                   block_wakeup_req_pulse,
	input  logic                   pwrup_ack,
	output logic                   pwrup_req,
	output logic                   clk_en,
	output logic                   stall_release,
	output power_pkg::link_state_t link_state
);

	// masked and synchronized interrupt wake request
	logic wfi_wakeup_req;

	// fabric acknowledge, already in the always-on domain
	logic ack_sync;

	irq_wake_sync u_irq_wake_sync (
		.clk_always_on  (clk_always_on),
		.rst_n          (rst_n),
		.irq            (irq),
		.irq_enable     (irq_enable),
		.wfi_wakeup_req (wfi_wakeup_req)
	);

	power_ctrl u_power_ctrl (
		.clk_always_on          (clk_always_on),
		.rst_n                  (rst_n),
		.allow_clkgate          (allow_clkgate),
		.allow_power_down       (allow_power_down),
		.allow_sleep_on_block   (allow_sleep_on_block),
		.frontend_pwrdown_ok    (frontend_pwrdown_ok),
		.sleeping_on_wfi        (sleeping_on_wfi),
		.sleeping_on_block      (sleeping_on_block),
		.wfi_wakeup_req         (wfi_wakeup_req),
		.block_wakeup_req_pulse (block_wakeup_req_pulse),
		.ack_sync               (ack_sync),
		.pwrup_req              (pwrup_req),
		.clk_en                 (clk_en),
		.stall_release          (stall_release)
	);

	// the request goes both out to the fabric and into the link monitor
	pwrup_link u_pwrup_link (
		.clk_always_on (clk_always_on),
		.rst_n         (rst_n),
		.pwrup_req     (pwrup_req),
		.pwrup_ack     (pwrup_ack),
		.ack_sync      (ack_sync),
		.link_state    (link_state)
	);

endmodule

// File: source/pwrup_link.sv
// ----------------------------------------------------------
// power-up link side of the sleep/wake subsystem
// synchronizes the fabric's power-up acknowledge into the
// always-on domain and names the current phase of the
// four-phase request/acknowledge exchange
// ----------------------------------------------------------

`timescale 1ns/1ns

module pwrup_link (
	input  logic                   clk_always_on,
	input  logic                   rst_n,
	input  logic                   pwrup_req,
	input  logic                   pwrup_ack,
	output logic                   ack_sync,
	output power_pkg::link_state_t link_state
);
	import power_pkg::*;

	// ----------------------------------------------------------
	// acknowledge synchronizer
	// ----------------------------------------------------------

	// bit 0 samples the asynchronous ack, the top bit feeds power_ctrl
	logic [sync_stages-1:0] ack_q;

	// resets high, as the fabric is taken to be powered up out of reset
	// and power_ctrl holds its request high at the same time
	always_ff @(posedge clk_always_on or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= '1;
		end else begin
			ack_q[0] <= pwrup_ack;
			for (int i = 1; i < sync_stages; i++) begin
				ack_q[i] <= ack_q[i-1];
			end
		end
	end

	assign ack_sync = ack_q[sync_stages-1];

	// ----------------------------------------------------------
	// link phase
	// ----------------------------------------------------------

	// the request is already in this domain, so the phase follows the
	// request and the synchronized ack with no further delay
	// the phases then run up, dropping, down, raising and back to up
	always_comb begin
		case ({pwrup_req, ack_sync})
			2'b11: begin
				link_state = link_up;
			end
			2'b01: begin
				// request withdrawn, fabric has not answered yet
				link_state = link_dropping;
			end
			2'b00: begin
				link_state = link_down;
			end
			2'b10: begin
				// request back up, fabric still powering on
				link_state = link_raising;
			end
			default: begin
				link_state = link_up;
			end
		endcase
	end

endmodule

// File: test/power_subsys_chk.sv
// ----------------------------------------------------------
// concurrent assertions on the power state machine
// bound into power_ctrl from the testbench; each failure
// is counted so the testbench can see it at the end
// ----------------------------------------------------------

`timescale 1ns/1ns

module power_subsys_chk (
	input logic                    clk_always_on,
	input logic                    rst_n,
	input logic                    allow_clkgate,
	input logic                    allow_power_down,
	input logic                    sleeping_on_wfi,
	input logic                    sleeping_on_block,
	input logic                    stall_release,
	input power_pkg::sleep_state_t state
);
	import power_pkg::*;

	// one counter per property, read back by the testbench
	int unsigned fail_sleep_kinds        = 0;
	int unsigned fail_double_pulse       = 0;
	int unsigned fail_release_awake      = 0;
	int unsigned fail_asleep_unpermitted = 0;

	// the core stalls on one thing at a time
	a_sleep_kinds: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		!(sleeping_on_wfi && sleeping_on_block))
		else begin
			fail_sleep_kinds++;
			$error("sleeping_on_wfi and sleeping_on_block are high together");
		end

	// release is a single cycle pulse
	a_double_pulse: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		stall_release |=> !stall_release)
		else begin
			fail_double_pulse++;
			$error("stall_release was high on two cycles in a row");
		end

	a_release_awake: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		stall_release |-> (sleeping_on_wfi || sleeping_on_block))
		else begin
			fail_release_awake++;
			$error("stall_release pulsed while the core was not stalled");
		end

	// a low power state needs at least one permission bit
	a_asleep_unpermitted: assert property (@(posedge clk_always_on) disable iff (!rst_n)
		(state == st_asleep) |-> (allow_clkgate || allow_power_down))
		else begin
			fail_asleep_unpermitted++;
			$error("st_asleep reached with neither clock gating nor power down allowed");
		end

endmodule

// File: test/power_subsys_tb.sv
// ----------------------------------------------------------
// testbench for the always-on sleep/wake subsystem
// stands in for the core, the CSR file and the fabric power
// controller, and walks a table of sleep scenarios through
// power_subsys_top, checking every result as it goes
// ----------------------------------------------------------

`timescale 1ns/1ns

module power_subsys_tb;
	import power_pkg::*;

	localparam int reset_cycles       = 10;
	localparam int drive_delay        = 10;
	localparam int num_rows           = 8;
	localparam int masked_wait_cycles = 40;
	localparam int timeout_cycles     = num_rows * 40 + reset_cycles;
	localparam int unsigned lcg_seed  = 84964;

	typedef logic [$clog2(num_irq)-1:0] line_t;

	// one scenario with its permission bits, sleep kind, wake source and asleep levels
	typedef struct packed {
		logic        clkgate;
		logic        power_down;
		logic        sleep_on_block;
		logic        on_block;
		logic        early_pulse;
		logic        wake_block;
		line_t       wake_line;
		logic        masked_probe;
		logic        exp_clk_en;
		logic        exp_pwrup_req;
		link_state_t exp_link;
	} row_t;

	logic        clk_always_on = 1'b0;
	logic        rst_n;
	irq_vec_t    irq;
	irq_vec_t    irq_enable;
	logic        allow_clkgate;
	logic        allow_power_down;
	logic        allow_sleep_on_block;
	logic        frontend_pwrdown_ok;
	logic        sleeping_on_wfi;
	logic        sleeping_on_block;
	logic        block_wakeup_req_pulse;
	logic        pwrup_ack;
	logic        pwrup_req;
	logic        clk_en;
	logic        stall_release;
	link_state_t link_state;

	row_t        rows [num_rows];
	// every change of link_state seen during the current row
	link_state_t link_trace [$];
	link_state_t last_link    = link_up;
	int          cycle_count  = 0;
	int unsigned lcg_state    = lcg_seed;

	power_subsys_top uut (.*);

	bind power_ctrl power_subsys_chk u_chk (
		.clk_always_on     (clk_always_on),
		.rst_n             (rst_n),
		.allow_clkgate     (allow_clkgate),
		.allow_power_down  (allow_power_down),
		.sleeping_on_wfi   (sleeping_on_wfi),
		.sleeping_on_block (sleeping_on_block),
		.stall_release     (stall_release),
		.state             (state)
	);

	always #50 clk_always_on = ~clk_always_on;

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	task automatic stop_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_link(input string name, input link_state_t actual,
			input link_state_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s expected %s, got %s", $time, name,
				expected.name(), actual.name());
			stop_with_failure();
		end
	endtask

	// outputs are read a little after the edge, where they have settled,
	// and inputs change at that same point, well clear of the next edge
	task automatic next_cycle();
		@(posedge clk_always_on);
		#drive_delay;
		if (link_state != last_link) begin
			link_trace.push_back(link_state);
			last_link = link_state;
		end
	endtask

	// a line outside the mask must never end the stall
	task automatic probe_masked_line(input line_t line);
		irq = irq_vec_t'(1) << line;
		repeat (masked_wait_cycles) begin
			next_cycle();
			check_bit("stall_release", stall_release, 1'b0);
		end
		irq = '0;
	endtask

	// a power-down sleep has to walk all four handshake phases in order,
	// any other sleep leaves the link up the whole time
	task automatic check_trace(input logic power_cycled);
		link_state_t expected [4];
		expected = '{link_dropping, link_down, link_raising, link_up};
		if (!power_cycled) begin
			if (link_trace.size() != 0) begin
				$display("link_state left link_up during a sleep that kept power on");
				stop_with_failure();
			end
		end else if (link_trace.size() != 4) begin
			$display("link_state went through %0d phases, the power handshake has 4",
				link_trace.size());
			stop_with_failure();
		end else begin
			for (int i = 0; i < 4; i++) begin
				check_link("link_state phase", link_trace[i], expected[i]);
			end
		end
	endtask

	task automatic run_row(input row_t r);
		logic        clk_en_before;
		link_state_t link_before;
		allow_clkgate        = r.clkgate;
		allow_power_down     = r.power_down;
		allow_sleep_on_block = r.sleep_on_block;
		irq_enable           = r.wake_block ? irq_vec_t'(0) : irq_vec_t'(1) << r.wake_line;
		link_trace.delete();
		next_cycle();
		next_cycle();
		if (r.early_pulse) begin
			// unblock arrives while the core is still running
			block_wakeup_req_pulse = 1'b1;
			next_cycle();
			block_wakeup_req_pulse = 1'b0;
			next_cycle();
		end
		sleeping_on_wfi     = !r.on_block;
		sleeping_on_block   = r.on_block;
		frontend_pwrdown_ok = 1'b1;
		next_cycle();
		if (r.early_pulse) begin
			check_bit("stall_release", stall_release, 1'b1);
		end else begin
			// power removal is done once the fabric has dropped its ack
			while (r.exp_link == link_down && link_state != link_down) begin
				next_cycle();
			end
			next_cycle();
			check_bit("stall_release", stall_release, 1'b0);
		end
		check_bit("clk_en", clk_en, r.exp_clk_en);
		check_bit("pwrup_req", pwrup_req, r.exp_pwrup_req);
		check_link("link_state", link_state, r.exp_link);
		if (!r.early_pulse) begin
			if (r.masked_probe) begin
				probe_masked_line(r.wake_line + 1'b1);
			end
			if (r.wake_block) begin
				block_wakeup_req_pulse = 1'b1;
				next_cycle();
				block_wakeup_req_pulse = 1'b0;
			end else begin
				irq = irq_vec_t'(1) << r.wake_line;
			end
			clk_en_before = clk_en;
			link_before   = link_state;
			while (stall_release !== 1'b1) begin
				clk_en_before = clk_en;
				link_before   = link_state;
				next_cycle();
			end
			// clock and link are back up a cycle ahead of the release pulse
			check_bit("clk_en", clk_en_before, 1'b1);
			check_link("link_state", link_before, link_up);
		end
		// the core only continues with power and clock fully back
		check_bit("clk_en", clk_en, 1'b1);
		check_bit("pwrup_req", pwrup_req, 1'b1);
		check_link("link_state", link_state, link_up);
		// the stall stays visible through the pulse cycle, then the core leaves it
		next_cycle();
		check_bit("stall_release", stall_release, 1'b0);
		sleeping_on_wfi     = 1'b0;
		sleeping_on_block   = 1'b0;
		frontend_pwrdown_ok = 1'b0;
		irq                 = '0;
		next_cycle();
		next_cycle();
		check_bit("stall_release", stall_release, 1'b0);
		check_trace(!r.exp_pwrup_req);
	endtask

	// ----------------------------------------------------------
	// fabric power controller and watchdog
	// ----------------------------------------------------------

	// answers each edge of the request after 1 to 6 cycles
	initial begin : fabric_model
		int unsigned delay;
		pwrup_ack = 1'b1;
		forever begin
			@(posedge clk_always_on);
			#drive_delay;
			if (rst_n && pwrup_req !== pwrup_ack) begin
				delay = 1 + lcg_next() % 6;
				repeat (delay) @(posedge clk_always_on);
				#drive_delay;
				pwrup_ack = pwrup_req;
			end
		end
	end

	always @(posedge clk_always_on) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			$display("timeout: the scenarios did not finish within %0d cycles", timeout_cycles);
			stop_with_failure();
		end
	end

	// ----------------------------------------------------------
	// scenario table and main sequence
	// ----------------------------------------------------------

	initial begin
		// cg, pd, sob, on_block, early, wake_block, line, probe, clk_en, pwrup_req, link
		rows[0] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1, 1'b1, 1'b1, link_up};
		rows[1] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1, 1'b0, 1'b0, 1'b1, link_up};
		rows[2] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd2, 1'b0, 1'b1, 1'b0, link_down};
		rows[3] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd3, 1'b0, 1'b0, 1'b0, link_down};
		// sticky unblock, then a block that has to wait for its own pulse
		rows[4] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 2'd0, 1'b0, 1'b1, 1'b1, link_up};
		rows[5] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, link_up};
		// without allow_sleep_on_block a block keeps full power
		rows[6] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 2'd0, 1'b0, 1'b1, 1'b1, link_up};
		rows[7] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 2'd2, 1'b0, 1'b1, 1'b0, link_down};

		rst_n                  = 1'b0;
		irq                    = '0;
		irq_enable             = '0;
		allow_clkgate          = 1'b0;
		allow_power_down       = 1'b0;
		allow_sleep_on_block   = 1'b0;
		frontend_pwrdown_ok    = 1'b0;
		sleeping_on_wfi        = 1'b0;
		sleeping_on_block      = 1'b0;
		block_wakeup_req_pulse = 1'b0;
		repeat (reset_cycles) @(posedge clk_always_on);
		#drive_delay;
		rst_n = 1'b1;
		next_cycle();
		check_bit("stall_release", stall_release, 1'b0);
		check_bit("clk_en", clk_en, 1'b1);
		check_bit("pwrup_req", pwrup_req, 1'b1);
		check_link("link_state", link_state, link_up);

		for (int i = 0; i < num_rows; i++) begin
			run_row(rows[i]);
		end

		if (uut.u_power_ctrl.u_chk.fail_sleep_kinds + uut.u_power_ctrl.u_chk.fail_double_pulse
				+ uut.u_power_ctrl.u_chk.fail_release_awake
				+ uut.u_power_ctrl.u_chk.fail_asleep_unpermitted != 0) begin
			$display("a concurrent assertion on the power state machine failed");
			stop_with_failure();
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule
